// File: Makefile
# Verilator build and run of the microphone level meter testbench

VERILATOR ?= verilator
TOP       ?= tb_mic_level_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "TEST PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: display_pkg.sv
//----------------------------------------------------------------------
// LED bar display definitions
// Bar width, bar type and the level-to-LED scaling constants
//----------------------------------------------------------------------

package display_pkg;

    // Number of LEDs in the level bar
    localparam int LED_COUNT = 8;

    // One bit per LED, bit 0 is the bottom of the bar
    typedef logic [LED_COUNT-1:0] led_bar_t;

    // Level step that lights one more LED
    // Full scale 2048 maps onto all eight LEDs
    localparam int LEVEL_PER_LED = 256;

    // Drop of the held peak on every window
    // At 64 per window a full-scale peak fades out after 32 windows
    localparam int PEAK_DECAY = 64;

endpackage

// File: led_bar_driver.sv
`timescale 1ns/1ps

//----------------------------------------------------------------------
// LED bar driver
// Turns level and held peak into a bar pattern plus a clip LED
//----------------------------------------------------------------------

module led_bar_driver
    import mic_pkg::*, display_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    level_if.display lvl,
    output led_bar_t led_bar,
    output logic     clip_led
);

    // Enough bits to count from zero to LED_COUNT inclusive
    localparam int CNT_W = $clog2(LED_COUNT + 1);

    logic [CNT_W-1:0] lit_cnt;
    logic [CNT_W-1:0] peak_cnt;
    led_bar_t         bar_next;

    // Number of whole LED steps in a level, capped at the bar length
    function automatic logic [CNT_W-1:0] led_steps(input level_t value);
        int unsigned steps;
        steps = int'(value) / LEVEL_PER_LED;
        if (steps > LED_COUNT)
            steps = LED_COUNT;
        return CNT_W'(steps);
    endfunction

    assign lit_cnt  = led_steps(lvl.level);
    assign peak_cnt = led_steps(lvl.peak);

    // Solid bar up to the level plus a single dot at the held peak
    always_comb
    begin
        bar_next = '0;
        for (int i = 0; i < LED_COUNT; i++)
        begin
            if (i < int'(lit_cnt))
                bar_next[i] = 1'b1;
            // Peak dot sits on the top LED of its own bar
            if (peak_cnt != '0 && i == int'(peak_cnt) - 1)
                bar_next[i] = 1'b1;
        end
    end

    // Outputs change only when the meter publishes a window
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            led_bar  <= '0;
            clip_led <= 1'b0;
        end
        else if (lvl.valid)
        begin
            led_bar  <= bar_next;
            clip_led <= lvl.clip;
        end
    end

endmodule

// File: level_if.sv
`timescale 1ns/1ps

//----------------------------------------------------------------------
// Meter to display link
// Carries level, peak, clip and the per-window valid pulse
//----------------------------------------------------------------------

interface level_if
    import mic_pkg::*;
();

    // Largest distance from mid-scale seen in the last window
    level_t level;
    // Decaying peak-hold value
    level_t peak;
    // A clipped code was seen in the last window
    logic   clip;
    // One-cycle pulse, the three fields above are new
    logic   valid;

    // The meter produces all fields
    modport meter (output level, output peak, output clip, output valid);

    // The display only consumes them
    modport display (input level, input peak, input clip, input valid);

endinterface

// File: level_meter.sv
`timescale 1ns/1ps

//----------------------------------------------------------------------
// Audio level meter
// Windowed peak magnitude, decaying peak hold and clip detection
//----------------------------------------------------------------------

module level_meter
    import mic_pkg::*, display_pkg::*;
#(
    parameter int window_len = 1024
)
(
    input  logic    clk,
    input  logic    rst,
    input  sample_t sample,
    input  logic    sample_ready,
    level_if.meter  lvl
);

    // Window length is a power of two, so the counter wraps by itself
    localparam int WIN_W = (window_len > 1) ? $clog2(window_len) : 1;

    logic [WIN_W-1:0] win_cnt;
    level_t           mag;
    level_t           max_acc;
    level_t           max_next;
    level_t           peak_decayed;
    logic             clip_acc;
    logic             clip_now;
    logic             win_last;

    //------------------------------------------------------------------
    // Per-sample arithmetic
    //------------------------------------------------------------------

    // Distance from silence, zero maps to 2048 and top code to 2047
    assign mag = (sample >= SAMPLE_MID) ? sample - SAMPLE_MID : SAMPLE_MID - sample;

    // Running maximum including the current sample
    assign max_next = (mag > max_acc) ? mag : max_acc;

    // Either rail of the converter counts as clipping
    assign clip_now = (sample == SAMPLE_MAX) || (sample == '0);

    // The current sample closes the window
    assign win_last = (win_cnt == WIN_W'(window_len - 1));

    // Held peak after one step of decay, floored at zero
    assign peak_decayed = (lvl.peak > level_t'(PEAK_DECAY)) ?
                          lvl.peak - level_t'(PEAK_DECAY) : '0;

    //------------------------------------------------------------------
    // Window accumulation and publishing
    //------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            win_cnt   <= '0;
            max_acc   <= '0;
            clip_acc  <= 1'b0;
            lvl.level <= '0;
            lvl.peak  <= '0;
            lvl.clip  <= 1'b0;
            lvl.valid <= 1'b0;
        end
        else
        begin
            lvl.valid <= 1'b0;
            if (sample_ready)
            begin
                win_cnt <= win_cnt + WIN_W'(1);
                if (win_last)
                begin
                    // Publish the finished window
                    lvl.level <= max_next;
                    lvl.clip  <= clip_acc | clip_now;
                    // A louder window replaces the decayed peak
                    lvl.peak  <= (max_next > peak_decayed) ? max_next : peak_decayed;
                    lvl.valid <= 1'b1;
                    // Start the next window empty
                    max_acc   <= '0;
                    clip_acc  <= 1'b0;
                end
                else
                begin
                    max_acc  <= max_next;
                    clip_acc <= clip_acc | clip_now;
                end
            end
        end
    end

endmodule

// File: mic_level_top.sv
`timescale 1ns/1ps

//----------------------------------------------------------------------
// Microphone level meter top level
// Receiver, level meter and LED bar driver in a chain
//----------------------------------------------------------------------

module mic_level_top
    import mic_pkg::*, display_pkg::*;
#(
    parameter int clk_mhz       = 50,
    parameter int samplerate_hz = 48000,
    parameter int left_right    = 0,
    parameter int window_len    = 1024
)
(
    input  logic     clk,
    input  logic     rst,
    output logic     cs,
    output logic     sck,
    input  logic     sdo,
    output sample_t  sample,
    output logic     sample_ready,
    output led_bar_t led_bar,
    output logic     clip_led
);

    // Level results travel from meter to display on this bus
    level_if lvl_bus ();

    // Serial front end, its raw stream also leaves the chip
    mic_spi_receiver #(
        .clk_mhz       (clk_mhz),
        .samplerate_hz (samplerate_hz),
        .left_right    (left_right)
    ) u_receiver (
        .clk          (clk),
        .rst          (rst),
        .cs           (cs),
        .sck          (sck),
        .sdo          (sdo),
        .sample       (sample),
        .sample_ready (sample_ready)
    );

    // One level result per window of samples
    level_meter #(
        .window_len (window_len)
    ) u_meter (
        .clk          (clk),
        .rst          (rst),
        .sample       (sample),
        .sample_ready (sample_ready),
        .lvl          (lvl_bus.meter)
    );

    // Bar display, updated one clock after each level result
    led_bar_driver u_display (
        .clk      (clk),
        .rst      (rst),
        .lvl      (lvl_bus.display),
        .led_bar  (led_bar),
        .clip_led (clip_led)
    );

endmodule

// File: mic_pkg.sv
//----------------------------------------------------------------------
// Microphone path definitions
// Sample and level types and the serial frame constants
//----------------------------------------------------------------------

package mic_pkg;

    // Width of one converter sample
    localparam int SAMPLE_W = 12;

    // Raw unsigned sample as delivered by the ADC, 0 to 4095
    typedef logic [SAMPLE_W-1:0] sample_t;

    // Distance of a sample from mid-scale, 0 to 2048
    typedef logic [SAMPLE_W-1:0] level_t;

    // Bits in one serial data frame, four leading zeros and twelve data bits
    localparam int FRAME_BITS = 16;

    // Code the converter reports for silence
    localparam sample_t SAMPLE_MID = 12'd2048;

    // Top code of the converter; it and zero count as clipping
    localparam sample_t SAMPLE_MAX = 12'd4095;

endpackage

// File: mic_spi_receiver.sv
`timescale 1ns/1ps

//----------------------------------------------------------------------
// PMOD MIC3 serial receiver
// Drives sck and chip select, shifts in frames, emits 12-bit samples
//----------------------------------------------------------------------

module mic_spi_receiver
    import mic_pkg::*;
#(
    parameter int clk_mhz       = 50,
    parameter int samplerate_hz = 48000,
    parameter int left_right    = 0
)
(
    input  logic    clk,
    input  logic    rst,
    output logic    cs,
    output logic    sck,
    input  logic    sdo,
    output sample_t sample,
    output logic    sample_ready
);

    //------------------------------------------------------------------
    // Timing constants
    //------------------------------------------------------------------

    // One sample period is 2 * FRAME_BITS sck periods, each two halves
    // The half period of sck lasts SCK_MAX + 1 system clocks
    localparam int SCK_MAX = clk_mhz * 1000000 / samplerate_hz / (4 * FRAME_BITS);
    localparam int SCK_W   = (SCK_MAX > 0) ? $clog2(SCK_MAX + 1) : 1;

    // Bit counter covers both halves of the sample period
    localparam int BIT_W = $clog2(2 * FRAME_BITS);

    // First bit step after the selected half, where the frame is complete
    localparam logic [BIT_W-1:0] END_POS = (left_right == 0) ? BIT_W'(FRAME_BITS) : '0;

    logic [SCK_W-1:0]      sck_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] shift_reg;
    logic                  sck_step;
    logic                  bit_step;
    logic                  first_half;
    logic                  frame_end;

    // sck toggles when the prescaler reaches its end
    assign sck_step = (sck_cnt == SCK_W'(SCK_MAX));

    // A bit is taken on the rising edge of sck, i.e. while sck is still low
    assign bit_step = sck_step & ~sck;

    assign first_half = (bit_cnt < BIT_W'(FRAME_BITS));
    assign frame_end  = bit_step && (bit_cnt == END_POS);

    // Chip select is active low during the chosen half of the period
    assign cs = (left_right == 0) ? ~first_half : first_half;

    //------------------------------------------------------------------
    // Bit clock and bit position
    //------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sck_cnt      <= '0;
            sck          <= 1'b0;
            bit_cnt      <= '0;
            sample_ready <= 1'b0;
        end
        else
        begin
            sample_ready <= frame_end;
            if (sck_step)
            begin
                sck_cnt <= '0;
                sck     <= ~sck;
            end
            else
            begin
                sck_cnt <= sck_cnt + SCK_W'(1);
            end
            // Counter wraps from 31 back to 0 on its own
            if (bit_step)
                bit_cnt <= bit_cnt + BIT_W'(1);
        end
    end

    //------------------------------------------------------------------
    // Data path
    //------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        // Only bits clocked while the device is selected are data
        if (bit_step && !cs)
            shift_reg <= {shift_reg[FRAME_BITS-2:0], sdo};
        // The four leading zeros fall off, the 12 data bits remain
        if (frame_end)
            sample <= shift_reg[SAMPLE_W-1:0];
    end

endmodule

// File: sources.f
mic_pkg.sv
display_pkg.sv
level_if.sv
mic_spi_receiver.sv
level_meter.sv
led_bar_driver.sv
mic_level_top.sv
tb_mic_level_top.sv

// File: tb_mic_level_top.sv
`timescale 1ns/1ps

//----------------------------------------------------------------------
// Testbench for the microphone level meter
// Serial microphone model, sample scoreboard and directed tests
//----------------------------------------------------------------------

module tb_mic_level_top
    import mic_pkg::*, display_pkg::*;
();

    localparam int WINDOW_LEN = 4;
    // Half period of sck in clocks at 50 MHz and 48 kHz
    localparam int SCK_HALF = 17;
    // One sample period is 32 sck periods, i.e. 64 half periods
    localparam int FRAME_CLOCKS = 4 * FRAME_BITS * SCK_HALF;

    logic     clk;
    logic     rst;
    logic     sdo = 1'b0;
    logic     cs;
    logic     sck;
    sample_t  sample;
    logic     sample_ready;
    led_bar_t led_bar;
    logic     clip_led;

    // Words waiting to be sent, and words sent but not yet received
    sample_t tx_q[$];
    sample_t expect_q[$];

    integer seed;
    int errors = 0;
    int checks = 0;
    int frames_loaded = 0;
    int samples_seen = 0;
    int windows_closed = 0;

    // Microphone model state
    logic        prev_cs = 1'b1;
    logic        prev_sck = 1'b0;
    logic        bit_taken = 1'b0;
    logic [15:0] frame_word = '0;
    int          bit_idx = 0;

    // Window scoreboard state
    sample_t  mon_word;
    int       win_pos = 0;
    int       win_max = 0;
    logic     win_clip = 1'b0;
    int       model_level = 0;
    int       model_peak = 0;
    logic     model_clip = 1'b0;
    led_bar_t model_bar = '0;

    mic_level_top #(
        .clk_mhz       (50),
        .samplerate_hz (48000),
        .left_right    (0),
        .window_len    (WINDOW_LEN)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .cs           (cs),
        .sck          (sck),
        .sdo          (sdo),
        .sample       (sample),
        .sample_ready (sample_ready),
        .led_bar      (led_bar),
        .clip_led     (clip_led)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //------------------------------------------------------------------
    // Microphone model and scoreboard
    //------------------------------------------------------------------

    // Each frame is four zeros and the 12 data bits, MSB first
    // A bit changes on the sck fall after the receiver has clocked it in
    always @(posedge clk)
    begin
        if (rst)
        begin
            prev_cs = 1'b1;
            prev_sck = 1'b0;
            bit_taken = 1'b0;
        end
        else
        begin
            if (prev_cs && !cs)
            begin
                // An empty queue sends silence so the stream never stalls
                frame_word = {4'b0000, (tx_q.size() != 0) ? tx_q.pop_front() : SAMPLE_MID};
                expect_q.push_back(frame_word[11:0]);
                frames_loaded++;
                bit_idx = 15;
                bit_taken = 1'b0;
                sdo <= frame_word[15];
            end
            else if (!cs)
            begin
                if (!prev_sck && sck)
                    bit_taken = 1'b1;
                else if (prev_sck && !sck && bit_taken && bit_idx > 0)
                begin
                    bit_idx--;
                    bit_taken = 1'b0;
                    sdo <= frame_word[bit_idx];
                end
            end
            prev_cs = cs;
            prev_sck = sck;
        end
    end

    // Every received sample is compared with the sent word
    // The window rules then give the expected level, peak and clip
    always @(negedge clk)
    begin
        if (!rst && sample_ready)
        begin
            if (expect_q.size() == 0)
            begin
                errors++;
                $display("sample_ready pulsed while no frame was outstanding");
            end
            else
            begin
                mon_word = expect_q.pop_front();
                check_value("sample", 32'(sample), 32'(mon_word));
                if (distance(mon_word) > win_max)
                    win_max = distance(mon_word);
                if (mon_word == SAMPLE_MAX || mon_word == 12'd0)
                    win_clip = 1'b1;
                win_pos++;
                if (win_pos == WINDOW_LEN)
                begin
                    // Held peak drops by one step, a louder window replaces it
                    model_peak = (model_peak > PEAK_DECAY) ? model_peak - PEAK_DECAY : 0;
                    if (win_max > model_peak)
                        model_peak = win_max;
                    model_level = win_max;
                    model_clip = win_clip;
                    model_bar = bar_pattern(model_level, model_peak);
                    windows_closed++;
                    win_pos = 0;
                    win_max = 0;
                    win_clip = 1'b0;
                end
            end
            samples_seen++;
        end
    end

    //------------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------------

    function automatic int distance(input sample_t word);
        int w;
        w = int'(word);
        return (w >= int'(SAMPLE_MID)) ? w - int'(SAMPLE_MID) : int'(SAMPLE_MID) - w;
    endfunction

    // Solid bar of level/256 LEDs plus one dot at peak/256, both capped at eight
    function automatic led_bar_t bar_pattern(input int level, input int peak);
        int lit;
        int dot;
        led_bar_t bar;
        lit = (level / LEVEL_PER_LED > LED_COUNT) ? LED_COUNT : level / LEVEL_PER_LED;
        dot = (peak / LEVEL_PER_LED > LED_COUNT) ? LED_COUNT : peak / LEVEL_PER_LED;
        bar = led_bar_t'((32'd1 << lit) - 32'd1);
        if (dot >= 1)
            bar[dot - 1] = 1'b1;
        return bar;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // Waits until the queue is drained and the next frame starts on an aligned index
    task automatic wait_frame_slot(input int align, output int base);
        int t;
        t = 0;
        @(negedge clk);
        while ((tx_q.size() != 0 || frames_loaded % align != 0) && t < 8 * FRAME_CLOCKS)
        begin
            @(negedge clk);
            t++;
        end
        if (t >= 8 * FRAME_CLOCKS)
        begin
            errors++;
            $display("Timeout while waiting for a free frame slot");
        end
        base = frames_loaded;
    endtask

    task automatic wait_samples(input int target);
        int t;
        int limit;
        t = 0;
        limit = (target - samples_seen + 2) * FRAME_CLOCKS;
        @(posedge clk);
        while (samples_seen < target && t < limit)
        begin
            @(posedge clk);
            t++;
        end
        if (samples_seen < target)
        begin
            errors++;
            $display("Timeout while waiting for samples, got %0d of %0d", samples_seen, target);
        end
    endtask

    // Sends one aligned window and waits until the bar shows its result
    task automatic send_window(input int s0, input int s1, input int s2, input int s3);
        int base;
        wait_frame_slot(WINDOW_LEN, base);
        tx_q.push_back(sample_t'(s0));
        tx_q.push_back(sample_t'(s1));
        tx_q.push_back(sample_t'(s2));
        tx_q.push_back(sample_t'(s3));
        wait_samples(base + WINDOW_LEN);
        // Meter then display, one register each
        repeat (2) @(negedge clk);
    endtask

    task automatic check_display();
        check_value("led_bar", 32'(led_bar), 32'(model_bar));
        check_value("clip_led", 32'(clip_led), 32'(model_clip));
    endtask

    // Counts clocks between two sck edges
    task automatic check_sck_half_period();
        int n;
        logic last;
        @(negedge clk);
        last = sck;
        n = 0;
        while (sck == last && n < 4 * SCK_HALF)
        begin
            @(negedge clk);
            n++;
        end
        last = sck;
        n = 0;
        while (sck == last && n < 4 * SCK_HALF)
        begin
            @(negedge clk);
            n++;
        end
        if (n >= 4 * SCK_HALF)
        begin
            errors++;
            $display("Timeout while waiting for an sck edge");
        end
        else
            check_value("sck_half_period", 32'(n), 32'(SCK_HALF));
    endtask

    //------------------------------------------------------------------
    // Directed tests
    //------------------------------------------------------------------

    task automatic test_reset_state();
        @(negedge clk);
        check_value("sck", 32'(sck), 32'd0);
        check_value("sample_ready", 32'(sample_ready), 32'd0);
        check_value("led_bar", 32'(led_bar), 32'd0);
        check_value("clip_led", 32'(clip_led), 32'd0);
        check_value("cs", 32'(cs), 32'd0);
    endtask

    task automatic test_sample_capture();
        int base;
        check_sck_half_period();
        wait_frame_slot(1, base);
        for (int i = 0; i < 20; i++)
            tx_q.push_back(sample_t'($random(seed)));
        wait_samples(base + 20);
    endtask

    task automatic test_level_bar();
        int values[4] = '{2048, 2560, 3000, 1000};
        int v;
        for (int i = 0; i < 4; i++)
        begin
            v = values[i];
            send_window(2048, v, 2048 + (v - 2048) / 2, 2048);
            check_display();
        end
    endtask

    task automatic test_peak_decay();
        int loud_idx;
        int k;
        int p;
        int n;
        led_bar_t exp_bar;
        // Code 1 is 2047 below mid-scale without touching a rail
        send_window(2048, 1, 2048, 2048);
        check_display();
        loud_idx = windows_closed;
        p = 2047;
        n = 0;
        while (p >= LEVEL_PER_LED && n < 40)
        begin
            send_window(2048, 2048, 2048, 2048);
            k = windows_closed - loud_idx;
            p = 2047 - PEAK_DECAY * k;
            exp_bar = (p >= LEVEL_PER_LED) ?
                      led_bar_t'(32'd1 << (p / LEVEL_PER_LED - 1)) : '0;
            check_value("led_bar", 32'(led_bar), 32'(exp_bar));
            n++;
        end
    endtask

    task automatic test_clip();
        send_window(2048, 4095, 2100, 2048);
        check_value("clip_led", 32'(clip_led), 32'd1);
        check_display();
        send_window(2048, 2000, 2100, 2048);
        check_value("clip_led", 32'(clip_led), 32'd0);
        check_display();
        send_window(0, 2048, 2048, 2048);
        check_value("clip_led", 32'(clip_led), 32'd1);
        check_display();
        send_window(2048, 2048, 2048, 2048);
        check_value("clip_led", 32'(clip_led), 32'd0);
        check_display();
    endtask

    initial
    begin
        seed = 46;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_sample_capture();
        test_level_bar();
        test_peak_decay();
        test_clip();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
